/* src.f */
src/keypad_pkg.sv
src/calc_pkg.sv
src/keypad_scanner.sv
src/calc_engine.sv
src/display_converter.sv
src/calculator_top.sv
testbench/tb_clock.sv
testbench/keypad_model.sv
testbench/calculator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --timing --top-module calculator_tb -f src.f -o calc_sim > "$log" 2>&1 \
    && ./obj_dir/calc_sim >> "$log" 2>&1 \
    || echo "RESULT: FAIL" >> "$log"

cat "$log"
grep -q "RESULT: FAIL" "$log" && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

/* testbench/calculator_tb.sv */
`timescale 1ns/1ps

module calculator_tb
    import keypad_pkg::*;
    import calc_pkg::*;
;

    localparam int timeout_cycles   = 2000;
    localparam int no_update_cycles = 60;
    localparam int release_cycles   = 12;

    logic        clk;
    logic        nRST;
    logic [3:0]  row;
    logic [3:0]  col;
    bcd_digits_t digits;
    logic        negative;
    logic        display_valid;
    logic        press_a;
    logic        press_b;
    key_code_t   key_a;
    key_code_t   key_b;

    value_t      m_entry;       // Reference engine state
    int          m_count;
    value_t      m_acc;
    op_t         m_op;
    bit          m_active;
    value_t      m_shown;
    logic [31:0] rng_state;
    int          mismatch_count;
    int          timeout_count;
    int          unexpected_count;

    tb_clock clock_gen (.clk(clk), .nRST(nRST));

    keypad_model keypad (
        .col(col), .press_a(press_a), .key_a(key_a),
        .press_b(press_b), .key_b(key_b), .row(row)
    );

    calculator_top #(.debounce_cycles(8)) uut (
        .clk(clk), .nRST(nRST), .row(row), .col(col),
        .digits(digits), .negative(negative), .display_valid(display_valid)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic value_t to_value(int x);
        return value_t'(x);                   // Keeps the low 16 bits
    endfunction

    function automatic value_t apply_rule(op_t op, value_t a, value_t b);
        int x;
        case (op)
            op_add:  x = int'(a) + int'(b);
            op_sub:  x = int'(a) - int'(b);
            op_mul:  x = int'(a) * int'(b);
            default: x = int'(a);
        endcase
        return to_value(x);
    endfunction

    function automatic bcd_digits_t to_bcd(value_t v);
        bcd_digits_t d;
        int          m;
        m = int'(v);
        if (m < 0) begin
            m = -m;
        end
        for (int i = 0; i < display_digits; i++) begin
            d[i] = 4'(m % 10);
            m = m / 10;
        end
        return d;
    endfunction

    // Key index is column * 4 + row
    function automatic key_code_t digit_key(int d);
        case (d)
            1: return 4'd0;
            4: return 4'd1;
            7: return 4'd2;
            2: return 4'd4;
            5: return 4'd5;
            8: return 4'd6;
            3: return 4'd8;
            6: return 4'd9;
            9: return 4'd10;
            default: return 4'd7;             // Digit 0
        endcase
    endfunction

    function automatic key_code_t op_key(op_t op);
        case (op)
            op_add:  return 4'd12;
            op_sub:  return 4'd13;
            op_mul:  return 4'd14;
            default: return 4'd15;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_display(input bcd_digits_t exp_digits, input logic exp_neg,
                                 input string what);
        if (digits !== exp_digits || negative !== exp_neg) begin
            mismatch_count++;
            $display("FAILED at %0t: %s shows %s%h, expected %s%h", $time, what,
                     negative ? "-" : "+", digits, exp_neg ? "-" : "+", exp_digits);
        end
    endtask

    task automatic check_value(input value_t exp, input string what);
        int     mag;
        value_t got;
        mag = 0;
        for (int i = display_digits - 1; i >= 0; i--) begin
            mag = mag * 10 + int'(digits[i]);
        end
        got = to_value(negative ? -mag : mag);
        if (got !== exp) begin
            mismatch_count++;
            $display("FAILED at %0t: %s value %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_col(input logic [num_cols-1:0] exp, input string what);
        if (col !== exp) begin
            mismatch_count++;
            $display("FAILED at %0t: %s drives columns %b, expected %b",
                     $time, what, col, exp);
        end
    endtask

    // Every column must be driven low alone once per full scan
    task automatic check_scan(input string what);
        logic [num_cols-1:0] driven;
        driven = '0;
        for (int n = 0; n < num_cols; n++) begin
            next_cycle();
            if (!$onehot(~col)) begin
                mismatch_count++;
                $display("FAILED at %0t: %s drives columns %b, expected a single low",
                         $time, what, col);
            end
            driven = driven | ~col;
        end
        if (driven !== '1) begin
            mismatch_count++;
            $display("FAILED at %0t: %s drove columns %b low in %0d cycles, expected all",
                     $time, what, driven, num_cols);
        end
    endtask

    task automatic show_expected(input value_t v, input string what);
        check_display(to_bcd(v), v < 0, what);
        check_value(v, what);
    endtask

    task automatic wait_display(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < timeout_cycles) begin
            next_cycle();
            n++;
            if (display_valid === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            timeout_count++;
            $display("Timeout at %0t: no display update within %0d cycles",
                     $time, timeout_cycles);
        end
    endtask

    task automatic watch_quiet(input int cycles, input string what);
        for (int n = 0; n < cycles; n++) begin
            next_cycle();
            if (display_valid !== 1'b0) begin
                unexpected_count++;
                $display("Unexpected display update at %0t during %s", $time, what);
            end
        end
    endtask

    task automatic press_key(input key_code_t k, input bit expect_update, input value_t exp,
                             input int extra_hold, input string what);
        bit seen;
        key_a   = k;
        press_a = 1'b1;
        if (expect_update) begin
            wait_display(seen);
            if (seen) begin
                show_expected(exp, what);
            end
        end else begin
            watch_quiet(no_update_cycles, what);
            show_expected(exp, what);         // Display must not move
        end
        if (extra_hold > 0) begin
            watch_quiet(extra_hold, what);
        end
        press_a = 1'b0;
        watch_quiet(release_cycles, what);    // Release scan
    endtask

    task automatic press_digit(input int d, input int hold, input string what);
        if (m_count < max_entry_digits) begin
            m_entry  = to_value(int'(m_entry) * 10 + d);
            m_count++;
            m_active = 1'b1;
            m_shown  = m_entry;
            press_key(digit_key(d), 1'b1, m_shown, hold, what);
        end else begin
            press_key(digit_key(d), 1'b0, m_shown, hold, what);
        end
    endtask

    task automatic press_op(input op_t op, input string what);
        if (op == op_neg) begin
            if (m_active) begin
                m_entry = to_value(-int'(m_entry));
                m_shown = m_entry;
            end else begin
                m_acc   = to_value(-int'(m_acc));
                m_shown = m_acc;
            end
        end else begin
            if (m_active) begin
                m_acc = apply_rule(m_op, m_acc, m_entry);
            end
            m_shown  = m_acc;
            m_op     = op;
            m_entry  = '0;
            m_count  = 0;
            m_active = 1'b0;
        end
        press_key(op_key(op), 1'b1, m_shown, 0, what);
    endtask

    task automatic press_equal(input string what);
        m_acc    = apply_rule(m_op, m_acc, m_entry);
        m_op     = op_add;
        m_entry  = '0;
        m_count  = 0;
        m_active = 1'b0;
        m_shown  = m_acc;
        press_key(4'd3, 1'b1, m_shown, 0, what);
    endtask

    task automatic enter_number(input int n, input string what);
        int p;
        int d;
        bit started;
        started = 1'b0;
        if (n == 0) begin
            press_digit(0, 0, what);
        end else begin
            for (p = 1000; p > 0; p = p / 10) begin
                d = (n / p) % 10;
                if (d != 0 || started) begin
                    started = 1'b1;
                    press_digit(d, 0, what);
                end
            end
        end
    endtask

    // Times zero leaves the accumulator at 0
    task automatic clear_acc();
        press_op(op_mul, "clear");
        press_digit(0, 0, "clear");
        press_equal("clear");
    endtask

    task automatic test_reset();
        watch_quiet(100, "idle after reset");
        show_expected('0, "reset display");
        check_scan("idle scan");
    endtask

    task automatic test_digits();
        int group_a[4] = '{1, 4, 7, 0};
        int group_b[4] = '{2, 5, 8, 3};
        int group_c[2] = '{6, 9};
        foreach (group_a[i]) press_digit(group_a[i], 0, "digit entry");
        press_digit(9, 0, "fifth digit");
        press_equal("digit equal");
        foreach (group_b[i]) press_digit(group_b[i], 0, "digit entry");
        press_equal("digit equal");
        foreach (group_c[i]) press_digit(group_c[i], 0, "digit entry");
        press_equal("digit equal");
    endtask

    task automatic test_random();
        int  a;
        int  b;
        op_t op;
        for (int i = 0; i < 20; i++) begin
            rng_state = xorshift32(rng_state);
            a = int'(rng_state % 32'd10000);
            rng_state = xorshift32(rng_state);
            b = int'(rng_state % 32'd10000);
            rng_state = xorshift32(rng_state);
            op = op_t'(2'(rng_state % 32'd3));
            clear_acc();
            enter_number(a, $sformatf("pair %0d operand a", i));
            press_op(op, $sformatf("pair %0d operator", i));
            enter_number(b, $sformatf("pair %0d operand b", i));
            press_equal($sformatf("pair %0d result", i));
        end
    endtask

    task automatic test_neg_chain();
        clear_acc();
        enter_number(25, "neg entry");
        press_op(op_neg, "negate entry");
        press_op(op_add, "add after neg");
        enter_number(7, "chain operand");
        press_equal("neg sum");
        press_op(op_neg, "negate result");
        press_op(op_sub, "chain sub");
        enter_number(30, "chain operand");
        press_equal("chain sub result");
        press_op(op_mul, "chain mul");
        enter_number(3, "chain operand");
        press_equal("chain mul result");
    endtask

    task automatic test_hold_and_multi();
        press_digit(4, 300, "long hold");
        press_a = 1'b1;
        key_a   = digit_key(5);
        press_b = 1'b1;
        key_b   = digit_key(9);
        watch_quiet(no_update_cycles, "two keys held");
        press_a = 1'b0;
        press_b = 1'b0;
        watch_quiet(release_cycles, "two keys released");
        show_expected(m_shown, "after two keys");
        press_key(4'd11, 1'b0, m_shown, 0, "hash key");
    endtask

    initial begin
        int n;
        press_a          = 1'b0;
        press_b          = 1'b0;
        key_a            = '0;
        key_b            = '0;
        m_entry          = '0;
        m_count          = 0;
        m_acc            = '0;
        m_op             = op_add;
        m_active         = 1'b0;
        m_shown          = '0;
        rng_state        = 32'h0c822577;
        mismatch_count   = 0;
        timeout_count    = 0;
        unexpected_count = 0;
        n = 0;
        while (nRST !== 1'b1 && n < timeout_cycles) begin
            next_cycle();
            n++;
            if (nRST === 1'b0) begin
                check_col('1, "reset");       // All columns idle in reset
            end
        end
        if (nRST !== 1'b1) begin
            timeout_count++;
            $display("Timeout: reset was never released");
        end
        next_cycle();
        test_reset();
        test_digits();
        test_random();
        test_neg_chain();
        test_hold_and_multi();
        $display("Errors: %0d value mismatches, %0d timeouts, %0d unexpected updates",
                 mismatch_count, timeout_count, unexpected_count);
        if (mismatch_count + timeout_count + unexpected_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/keypad_model.sv */
`timescale 1ns/1ps

// Matrix keypad with two contact slots, so a double press can be modeled
module keypad_model
    import keypad_pkg::*;
(
    input  logic [num_cols-1:0] col,
    input  logic                press_a,
    input  key_code_t           key_a,
    input  logic                press_b,
    input  key_code_t           key_b,
    output logic [num_rows-1:0] row
);

    logic hit_a;
    logic hit_b;

    always_comb begin
        row = '1;                             // Idle rows read high
        for (int c = 0; c < num_cols; c++) begin
            for (int r = 0; r < num_rows; r++) begin
                hit_a = press_a && (key_a == key_code_t'(c * num_rows + r));
                hit_b = press_b && (key_b == key_code_t'(c * num_rows + r));
                if (!col[c] && (hit_a || hit_b)) begin
                    row[r] = 1'b0;            // Closed switch pulls the row low
                end
            end
        end
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic nRST
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;    // 20 ns period
    end

    initial begin
        nRST = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2 nRST = 1'b1;                       // Released off the edge
    end

endmodule

/* src/calculator_top.sv */
`timescale 1ns/1ps

module calculator_top
    import keypad_pkg::*;
    import calc_pkg::*;
#(
    parameter int unsigned debounce_cycles = debounce_default
) (
    input  logic                clk,
    input  logic                nRST,
    input  logic [num_rows-1:0] row,
    output logic [num_cols-1:0] col,
    output bcd_digits_t         digits,
    output logic                negative,
    output logic                display_valid
);

    logic       key_valid;
    key_class_t key_class;
    logic [3:0] key_digit;
    op_t        key_op;
    logic       value_valid;
    value_t     value;

    keypad_scanner #(
        .debounce_cycles(debounce_cycles)
    ) u_scanner (
        .clk       (clk),
        .nRST      (nRST),
        .row       (row),
        .col       (col),
        .key_valid (key_valid),
        .key_class (key_class),
        .key_digit (key_digit),
        .key_op    (key_op)
    );

    calc_engine u_engine (
        .clk         (clk),
        .nRST        (nRST),
        .key_valid   (key_valid),
        .key_class   (key_class),
        .key_digit   (key_digit),
        .key_op      (key_op),
        .value_valid (value_valid),
        .value       (value)
    );

    display_converter u_converter (
        .clk           (clk),
        .nRST          (nRST),
        .value_valid   (value_valid),
        .value         (value),
        .display_valid (display_valid),
        .digits        (digits),
        .negative      (negative)
    );

endmodule

/* src/display_converter.sv */
`timescale 1ns/1ps

module display_converter
    import calc_pkg::*;
(
    input  logic        clk,
    input  logic        nRST,
    input  logic        value_valid,
    input  value_t      value,
    output logic        display_valid,
    output bcd_digits_t digits,
    output logic        negative
);

    localparam int step_w = $clog2(value_width + 1);

    logic                   busy;
    logic [step_w-1:0]      step;
    logic [value_width-1:0] mag;       // Shifts out msb first
    logic                   sign;
    bcd_digits_t            bcd_work;
    bcd_digits_t            bcd_adj;

    // Add 3 to every digit above 4 before the shift
    always_comb begin
        bcd_adj = bcd_work;
        for (int i = 0; i < display_digits; i++) begin
            if (bcd_work[i] > 4'd4) begin
                bcd_adj[i] = bcd_work[i] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy          <= 1'b0;
            step          <= '0;
            display_valid <= 1'b0;
            digits        <= '0;
            negative      <= 1'b0;
        end else begin
            display_valid <= 1'b0;
            if (value_valid) begin
                busy <= 1'b1;                 // Restart on every new value
                step <= '0;
            end else if (busy) begin
                if (step == step_w'(value_width)) begin
                    busy          <= 1'b0;
                    digits        <= bcd_work;
                    negative      <= sign;
                    display_valid <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // Working registers
    always_ff @(posedge clk) begin
        if (value_valid) begin
            sign     <= value[value_width-1];
            mag      <= value[value_width-1] ? -value : value;   // -32768 stays 0x8000
            bcd_work <= '0;
        end else if (busy && (step != step_w'(value_width))) begin
            {bcd_work, mag} <= {bcd_adj, mag} << 1;
        end
    end

endmodule

/* src/calc_engine.sv */
`timescale 1ns/1ps

module calc_engine
    import keypad_pkg::*;
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic       key_valid,
    input  key_class_t key_class,
    input  logic [3:0] key_digit,
    input  op_t        key_op,
    output logic       value_valid,
    output value_t     value
);

    localparam int count_w = $clog2(max_entry_digits + 1);

    value_t             entry;
    logic [count_w-1:0] entry_count;
    value_t             acc;
    op_t                pend_op;
    logic               entry_active;

    value_t digit_entry;
    value_t op_result;
    logic   entry_full;

    // Pending operator is never neg, neg acts at once
    function automatic value_t apply_op(op_t op, value_t a, value_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_mul:  return a * b;     // Low 16 bits kept
            default: return a;
        endcase
    endfunction

    assign digit_entry = entry * value_t'(10) + value_t'(key_digit);
    assign op_result   = apply_op(pend_op, acc, entry);
    assign entry_full  = (entry_count == count_w'(max_entry_digits));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry        <= '0;
            entry_count  <= '0;
            acc          <= '0;
            pend_op      <= op_add;
            entry_active <= 1'b0;
            value_valid  <= 1'b0;
            value        <= '0;
        end else begin
            value_valid <= 1'b0;
            if (key_valid) begin
                case (key_class)
                    keypad_pkg::key_digit: begin
                        if (!entry_full) begin        // Extra digits dropped silently
                            entry        <= digit_entry;
                            entry_count  <= entry_count + 1'b1;
                            entry_active <= 1'b1;
                            value        <= digit_entry;
                            value_valid  <= 1'b1;
                        end
                    end
                    key_operator: begin
                        if (key_op == op_neg) begin
                            if (entry_active) begin
                                entry <= -entry;
                                value <= -entry;
                            end else begin
                                acc   <= -acc;
                                value <= -acc;
                            end
                            value_valid <= 1'b1;
                        end else begin
                            if (entry_active) begin
                                acc   <= op_result;   // Commit the entry
                                value <= op_result;
                            end else begin
                                value <= acc;
                            end
                            pend_op      <= key_op;
                            entry        <= '0;
                            entry_count  <= '0;
                            entry_active <= 1'b0;
                            value_valid  <= 1'b1;
                        end
                    end
                    key_equal: begin
                        acc          <= op_result;
                        value        <= op_result;
                        pend_op      <= op_add;       // Next operator chains on the result
                        entry        <= '0;
                        entry_count  <= '0;
                        entry_active <= 1'b0;
                        value_valid  <= 1'b1;
                    end
                    default: ;                        // '#' does nothing
                endcase
            end
        end
    end

endmodule

/* src/keypad_scanner.sv */
`timescale 1ns/1ps

module keypad_scanner
    import keypad_pkg::*;
    import calc_pkg::*;
#(
    parameter int unsigned debounce_cycles = debounce_default
) (
    input  logic                clk,
    input  logic                nRST,
    input  logic [num_rows-1:0] row,
    output logic [num_cols-1:0] col,
    output logic                key_valid,
    output key_class_t          key_class,
    output logic [3:0]          key_digit,
    output op_t                 key_op
);

    localparam int num_keys = num_cols * num_rows;
    localparam int cnt_w    = $clog2(debounce_cycles + 1);

    typedef enum logic [1:0] {
        st_scan,
        st_debounce,
        st_confirm,
        st_wait_release
    } state_t;

    state_t state;

    logic [1:0]          col_idx;      // Column currently driven
    logic                col_on;       // Low until the first column is driven
    logic [1:0]          next_idx;
    logic [num_keys-1:0] img_work;     // Image being assembled
    logic [num_keys-1:0] frame;        // Last complete image
    logic                frame_done;
    logic                frame_onehot;
    key_code_t           frame_code;
    key_code_t           held_code;
    logic [cnt_w-1:0]    deb_cnt;
    logic                fire;

    assign next_idx = col_on ? col_idx + 2'd1 : col_idx;

    // Column drive, one column per cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            col        <= '1;
            col_idx    <= '0;
            col_on     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            col        <= ~(4'b0001 << next_idx);   // Active low
            col_idx    <= next_idx;
            col_on     <= 1'b1;
            frame_done <= col_on && (col_idx == 2'(num_cols - 1));
        end
    end

    // Rows answer for the column driven in the previous cycle
    always_ff @(posedge clk) begin
        if (col_on) begin
            img_work[col_idx*num_rows +: num_rows] <= ~row;
            if (col_idx == 2'(num_cols - 1)) begin
                frame <= {~row, img_work[num_keys-num_rows-1:0]};
            end
        end
    end

    assign frame_onehot = $onehot(frame);

    always_comb begin
        frame_code = '0;
        for (int i = 0; i < num_keys; i++) begin
            if (frame[i]) begin
                frame_code = key_code_t'(i);
            end
        end
    end

    assign fire = (state == st_confirm) && frame_done && frame_onehot &&
                  (frame_code == held_code);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= st_scan;
            deb_cnt   <= '0;
            held_code <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= fire;
            case (state)
                st_scan: begin
                    deb_cnt <= '0;
                    if (frame_done && frame_onehot) begin
                        held_code <= frame_code;
                        state     <= st_debounce;
                    end
                end
                st_debounce: begin
                    deb_cnt <= deb_cnt + 1'b1;
                    if (deb_cnt == cnt_w'(debounce_cycles - 1)) begin
                        state <= st_confirm;
                    end
                end
                st_confirm: begin
                    if (fire) begin
                        state <= st_wait_release;
                    end else if (frame_done) begin
                        state <= st_scan;            // Bounce or a second key
                    end
                end
                st_wait_release: begin
                    if (frame_done && (frame == '0)) begin
                        state <= st_scan;
                    end
                end
                default: state <= st_scan;
            endcase
        end
    end

    // Event payload, qualified by key_valid
    always_ff @(posedge clk) begin
        if (fire) begin
            key_class <= key_class_of(held_code);
            key_digit <= key_digit_of(held_code);
            key_op    <= op_t'(held_code[1:0]);  // Row selects the operator
        end
    end

endmodule

/* src/calc_pkg.sv */
package calc_pkg;

    localparam int value_width = 16;

    // Arithmetic wraps in two's complement
    typedef logic signed [value_width-1:0] value_t;

    localparam int max_entry_digits = 4;
    localparam int display_digits   = 5;   // Enough for 32768

    // Encoding follows the row of the operator column
    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_mul,
        op_neg
    } op_t;

    // Digit 0 is the least significant
    typedef logic [display_digits-1:0][3:0] bcd_digits_t;

endpackage

/* src/keypad_pkg.sv */
package keypad_pkg;

    localparam int num_cols = 4;
    localparam int num_rows = 4;

    // Index is column * 4 + row
    typedef logic [3:0] key_code_t;

    typedef enum logic [1:0] {
        key_digit,
        key_operator,
        key_equal,
        key_none
    } key_class_t;

    localparam logic [20:0] debounce_default = 21'd2_000_000;   // About 40 ms at 50 MHz

    // Column 3 holds the operators while '*' is equal and '#' is none
    function automatic key_class_t key_class_of(key_code_t code);
        if (code[3:2] == 2'd3) begin
            return key_operator;
        end else if (code == 4'd3) begin
            return key_equal;
        end else if (code == 4'd11) begin
            return key_none;
        end
        return key_digit;
    endfunction

    // Phone style layout with 0 below 8
    function automatic logic [3:0] key_digit_of(key_code_t code);
        logic [3:0] c;
        logic [3:0] r;
        c = {2'b00, code[3:2]};
        r = {2'b00, code[1:0]};
        if (r == 4'd3) begin
            return 4'd0;
        end
        return r * 4'd3 + c + 4'd1;
    endfunction

endpackage
